/* pb_defs.svh */
/* Packet playback build parameters. Register addresses are 32-bit word
   addresses, and the data window covers the whole packet memory. */
`ifndef PB_DEFS_SVH
`define PB_DEFS_SVH

// Packet word and memory geometry
`define PB_DATA_BYTES      8
`define PB_DATA_WID        (`PB_DATA_BYTES * 8)
`define PB_MTY_WID         3
`define PB_MEM_BYTES       2048
`define PB_MEM_WORDS       (`PB_MEM_BYTES / `PB_DATA_BYTES)
`define PB_MEM_ADDR_WID    8
`define PB_WIN_ADDR_WID    9
`define PB_SIZE_WID        16
`define PB_META_WID        32
`define PB_TIMEOUT_CYCLES  1024

// Register map
`define PB_REG_ADDR_WID    10
`define PB_REG_CONTROL     0
`define PB_REG_CONFIG      1
`define PB_REG_COMMAND     2
`define PB_REG_STATUS      3
`define PB_REG_INFO        4
`define PB_REG_META        5
`define PB_REG_DATA_BASE   256
`define PB_REG_DATA_WORDS  (`PB_MEM_BYTES / 4)

`endif

/* pb_pkg.sv */
/* Command and status codes of the playback controller, and the register word
   that CONFIG and COMMAND writes are decoded through. */
`default_nettype none

package pb_pkg;

    typedef enum logic [1:0] {
        CMD_NOP             = 2'd0,
        CMD_SEND_ONE        = 2'd1,
        CMD_SEND_BURST      = 2'd2,
        CMD_SEND_CONTINUOUS = 2'd3
    } pb_cmd_e;

    // STOP reuses the NOP code, only meaningful during continuous sending
    localparam pb_cmd_e CMD_STOP = CMD_NOP;

    typedef enum logic [1:0] {
        STATUS_DISABLED = 2'd0,
        STATUS_READY    = 2'd1,
        STATUS_BUSY     = 2'd2
    } pb_status_e;

    // One write word, two meanings depending on the register address
    typedef union packed {
        struct packed {
            logic [15:0] burst_size;
            logic [15:0] packet_bytes;
        } cfg;
        struct packed {
            logic [29:0] rsvd;
            pb_cmd_e     code;
        } cmd;
    } pb_reg_word_u;

endpackage

`default_nettype wire

/* pb_regs.sv */
/* Register block on a single-clock bus. Read data follows reg_rd by one
   cycle; the data window is write only and reads back as zero. */
`timescale 1ns/10ps
`default_nettype none
`include "pb_defs.svh"

module pb_regs (
    input  logic                          clk,
    input  logic                          srst,
    input  logic                          reg_wr,
    input  logic                          reg_rd,
    input  logic [`PB_REG_ADDR_WID-1:0]   reg_addr,
    input  logic [31:0]                   reg_wdata,
    output logic [31:0]                   reg_rdata,
    output logic                          reg_rdata_vld,
    output logic                          enable,
    output logic                          cmd_evt,
    output pb_pkg::pb_cmd_e               cmd_code,
    output logic [`PB_SIZE_WID-1:0]       packet_bytes,
    output logic [`PB_SIZE_WID-1:0]       burst_size,
    output logic [`PB_META_WID-1:0]       meta,
    input  pb_pkg::pb_status_e            status_code,
    input  logic                          done,
    input  logic                          error,
    input  logic                          timeout,
    output logic                          mem_wr_en,
    output logic [`PB_WIN_ADDR_WID-1:0]   mem_wr_addr,
    output logic [31:0]                   mem_wr_data
);
    import pb_pkg::*;

    pb_reg_word_u                  wr_word;
    logic [`PB_REG_ADDR_WID-1:0]   win_off;
    logic                          in_window;
    logic                          status_rd;
    // Sticky flags as {timeout, error, done}
    logic [2:0]                    flags;

    assign wr_word   = reg_wdata;
    assign win_off   = reg_addr - `PB_REG_ADDR_WID'(`PB_REG_DATA_BASE);
    assign in_window = (reg_addr >= `PB_REG_DATA_BASE) &&
                       (reg_addr < `PB_REG_DATA_BASE + `PB_REG_DATA_WORDS);
    assign status_rd = reg_rd && (reg_addr == `PB_REG_STATUS);

    // Packet bytes go straight to the memory write port
    assign mem_wr_en   = reg_wr && in_window;
    assign mem_wr_addr = win_off[`PB_WIN_ADDR_WID-1:0];
    assign mem_wr_data = reg_wdata;

    // ------------------------------------------------------------------------
    // Writable registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            enable  <= 1'b0;
            cmd_evt <= 1'b0;
        end else begin
            cmd_evt <= reg_wr && (reg_addr == `PB_REG_COMMAND);
            if (reg_wr && (reg_addr == `PB_REG_CONTROL)) begin
                enable <= reg_wdata[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr) begin
            case (reg_addr)
                `PB_REG_CONFIG: begin
                    packet_bytes <= wr_word.cfg.packet_bytes;
                    burst_size   <= wr_word.cfg.burst_size;
                end
                `PB_REG_COMMAND: cmd_code <= wr_word.cmd.code;
                `PB_REG_META:    meta     <= reg_wdata;
                default: ;
            endcase
        end
    end

    // A pulse wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            flags <= 3'b000;
        end else begin
            flags <= (flags & {3{~(cmd_evt | status_rd)}}) | {timeout, error, done};
        end
    end

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            reg_rdata_vld <= 1'b0;
        end else begin
            reg_rdata_vld <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            case (reg_addr)
                `PB_REG_CONTROL: reg_rdata <= {31'd0, enable};
                `PB_REG_CONFIG:  reg_rdata <= {burst_size, packet_bytes};
                `PB_REG_STATUS:  reg_rdata <= {25'd0, flags, 2'b00, status_code};
                `PB_REG_INFO:    reg_rdata <= {16'(`PB_META_WID), 16'(`PB_MEM_BYTES)};
                `PB_REG_META:    reg_rdata <= meta;
                default:         reg_rdata <= 32'd0;
            endcase
        end
    end

    a_no_wr_rd : assert property (@(posedge clk) disable iff (srst) !(reg_wr && reg_rd));

endmodule

`default_nettype wire

/* pb_ctrl.sv */
/* Playback FSM. Sizes of zero or above the memory size are rejected; a STOP
   during continuous sending lets one more descriptor go out. */
`timescale 1ns/10ps
`default_nettype none
`include "pb_defs.svh"

module pb_ctrl (
    input  logic                      clk,
    input  logic                      srst,
    input  logic                      enable,
    input  logic                      cmd_evt,
    input  pb_pkg::pb_cmd_e           cmd_code,
    input  logic [`PB_SIZE_WID-1:0]   packet_bytes,
    input  logic [`PB_SIZE_WID-1:0]   burst_size,
    input  logic [`PB_META_WID-1:0]   meta,
    output pb_pkg::pb_status_e        status_code,
    output logic                      done,
    output logic                      error,
    output logic                      timeout,
    output logic                      desc_valid,
    output logic [`PB_SIZE_WID-1:0]   desc_size,
    output logic [`PB_META_WID-1:0]   desc_meta,
    input  logic                      desc_ready
);
    import pb_pkg::*;

    localparam int TMO_WID = $clog2(`PB_TIMEOUT_CYCLES);

    typedef enum logic [3:0] {
        ST_DISABLED, ST_READY, ST_SEND_ONE, ST_SEND_BURST, ST_SEND_CONT,
        ST_STOP, ST_DONE, ST_ERROR, ST_TIMEOUT
    } state_e;

    state_e                    state;
    state_e                    state_nxt;
    logic                      start;
    logic                      size_bad;
    logic                      tmo_hit;
    logic [TMO_WID-1:0]        tmo_cnt;
    logic [`PB_SIZE_WID-1:0]   burst_cnt;
    logic [`PB_SIZE_WID-1:0]   burst_last;

    assign start    = (state == ST_READY) && cmd_evt;
    assign size_bad = (packet_bytes == '0) || (packet_bytes > `PB_MEM_BYTES);
    assign tmo_hit  = (tmo_cnt == TMO_WID'(`PB_TIMEOUT_CYCLES - 1));

    // ------------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= ST_DISABLED;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_DISABLED: if (enable) state_nxt = ST_READY;
            ST_READY: begin
                if (!enable) state_nxt = ST_DISABLED;
                else if (cmd_evt) begin
                    if (cmd_code == CMD_NOP)             state_nxt = ST_DONE;
                    else if (size_bad)                   state_nxt = ST_ERROR;
                    else if (cmd_code == CMD_SEND_ONE)   state_nxt = ST_SEND_ONE;
                    else if (cmd_code == CMD_SEND_BURST) state_nxt = ST_SEND_BURST;
                    else                                 state_nxt = ST_SEND_CONT;
                end
            end
            ST_SEND_ONE, ST_STOP: begin
                if (desc_ready)   state_nxt = ST_DONE;
                else if (tmo_hit) state_nxt = ST_TIMEOUT;
            end
            ST_SEND_BURST: begin
                if (desc_ready) begin
                    if (burst_cnt == burst_last) state_nxt = ST_DONE;
                end else if (tmo_hit) begin
                    state_nxt = ST_TIMEOUT;
                end
            end
            ST_SEND_CONT: begin
                if (cmd_evt && (cmd_code == CMD_STOP)) state_nxt = ST_STOP;
                else if (!desc_ready && tmo_hit)       state_nxt = ST_TIMEOUT;
            end
            ST_DONE, ST_ERROR, ST_TIMEOUT: state_nxt = ST_READY;
            default: state_nxt = ST_DISABLED;
        endcase
    end

    // Packet context, held for the whole command
    always_ff @(posedge clk) begin
        if (start) begin
            desc_size  <= packet_bytes;
            desc_meta  <= meta;
            burst_last <= (burst_size == '0) ? '0 : burst_size - 1'b1;
            burst_cnt  <= '0;
        end else if (desc_ready) begin
            burst_cnt <= burst_cnt + 1'b1;
        end
    end

    // Restarts on every accepted descriptor
    always_ff @(posedge clk) begin
        if (srst) begin
            tmo_cnt <= '0;
        end else if (!desc_valid || desc_ready) begin
            tmo_cnt <= '0;
        end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------
    assign desc_valid = (state == ST_SEND_ONE) || (state == ST_SEND_BURST) ||
                        (state == ST_SEND_CONT) || (state == ST_STOP);
    assign done    = (state == ST_DONE);
    assign error   = (state == ST_ERROR);
    assign timeout = (state == ST_TIMEOUT);

    always_comb begin
        case (state)
            ST_DISABLED: status_code = STATUS_DISABLED;
            ST_SEND_ONE, ST_SEND_BURST, ST_SEND_CONT, ST_STOP: status_code = STATUS_BUSY;
            default:     status_code = STATUS_READY;
        endcase
    end

    // Only legal packet sizes are offered to the reader
    a_desc_size_legal : assert property (
        @(posedge clk) disable iff (srst)
        desc_valid |-> (desc_size != '0) && (desc_size <= `PB_MEM_BYTES));

endmodule

`default_nettype wire

/* pb_packet_mem.sv */
/* Packet RAM, no initialisation. Write window addresses are 32-bit words in
   network byte order; reads are registered with latency one. */
`timescale 1ns/10ps
`default_nettype none
`include "pb_defs.svh"

module pb_packet_mem (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [`PB_WIN_ADDR_WID-1:0]   wr_addr,
    input  logic [31:0]                   wr_data,
    input  logic                          rd_en,
    input  logic [`PB_MEM_ADDR_WID-1:0]   rd_addr,
    output logic [`PB_DATA_WID-1:0]       rd_data
);

    logic [`PB_DATA_WID-1:0] mem [`PB_MEM_WORDS];

    // Even window address is the upper half, so byte 0 lands in the top byte
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_addr[0]) begin
                mem[wr_addr[`PB_WIN_ADDR_WID-1:1]][31:0] <= wr_data;
            end else begin
                mem[wr_addr[`PB_WIN_ADDR_WID-1:1]][63:32] <= wr_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* pb_packet_read.sv */
/* Streams one packet per descriptor from address zero. Takes a descriptor
   only when idle; at most two words are buffered or in flight. */
`timescale 1ns/10ps
`default_nettype none
`include "pb_defs.svh"

module pb_packet_read (
    input  logic                          clk,
    input  logic                          srst,
    input  logic                          desc_valid,
    input  logic [`PB_SIZE_WID-1:0]       desc_size,
    input  logic [`PB_META_WID-1:0]       desc_meta,
    output logic                          desc_ready,
    output logic                          rd_en,
    output logic [`PB_MEM_ADDR_WID-1:0]   rd_addr,
    input  logic [`PB_DATA_WID-1:0]       rd_data,
    output logic                          pkt_valid,
    input  logic                          pkt_ready,
    output logic [`PB_DATA_WID-1:0]       pkt_data,
    output logic                          pkt_eop,
    output logic [`PB_MTY_WID-1:0]        pkt_mty,
    output logic [`PB_META_WID-1:0]       pkt_meta
);

    logic                          busy;
    logic                          rd_done;
    logic                          rd_pend;
    logic                          rd_pend_last;
    logic                          rd_last;
    logic [`PB_MEM_ADDR_WID-1:0]   rd_ptr;
    logic [`PB_MEM_ADDR_WID-1:0]   last_addr;
    logic [`PB_SIZE_WID-1:0]       size_m1;
    logic [`PB_MTY_WID-1:0]        mty_q;
    logic [`PB_META_WID-1:0]       meta_q;
    logic [1:0]                    occ;
    logic                          push;
    logic                          pop;

    // Two-entry output buffer
    logic [`PB_DATA_WID-1:0]       buf_data [2];
    logic [1:0]                    buf_eop;
    logic [1:0]                    buf_cnt;
    logic                          wr_sel;
    logic                          rd_sel;

    assign desc_ready = desc_valid && !busy;
    assign size_m1    = desc_size - 1'b1;
    assign pop        = pkt_valid && pkt_ready;
    assign push       = rd_pend;

    // Count a word leaving this cycle as free space
    assign occ     = buf_cnt + {1'b0, rd_pend};
    assign rd_en   = busy && !rd_done && ((occ < 2'd2) || ((occ == 2'd2) && pop));
    assign rd_addr = rd_ptr;
    assign rd_last = (rd_ptr == last_addr);

    // ------------------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            busy    <= 1'b0;
            rd_done <= 1'b0;
            rd_pend <= 1'b0;
            buf_cnt <= 2'd0;
            wr_sel  <= 1'b0;
            rd_sel  <= 1'b0;
        end else begin
            if (desc_ready) begin
                busy <= 1'b1;
            end else if (pop && pkt_eop) begin
                busy <= 1'b0;
            end
            if (desc_ready) begin
                rd_done <= 1'b0;
            end else if (rd_en && rd_last) begin
                rd_done <= 1'b1;
            end
            rd_pend <= rd_en;
            buf_cnt <= buf_cnt + {1'b0, push} - {1'b0, pop};
            if (push) wr_sel <= ~wr_sel;
            if (pop)  rd_sel <= ~rd_sel;
        end
    end

    // ------------------------------------------------------------------------
    // Descriptor context and data path
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (desc_ready) begin
            rd_ptr    <= '0;
            last_addr <= size_m1[`PB_MTY_WID +: `PB_MEM_ADDR_WID];
            mty_q     <= `PB_MTY_WID'(`PB_DATA_BYTES - desc_size[`PB_MTY_WID-1:0]);
            meta_q    <= desc_meta;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        rd_pend_last <= rd_en && rd_last;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_data[wr_sel] <= rd_data;
            buf_eop[wr_sel]  <= rd_pend_last;
        end
    end

    assign pkt_valid = (buf_cnt != 2'd0);
    assign pkt_data  = buf_data[rd_sel];
    assign pkt_eop   = buf_eop[rd_sel];
    assign pkt_mty   = pkt_eop ? mty_q : '0;
    assign pkt_meta  = meta_q;

    a_stall_stable : assert property (
        @(posedge clk) disable iff (srst)
        (pkt_valid && !pkt_ready) |=> pkt_valid && $stable(pkt_data) &&
            $stable(pkt_eop) && $stable(pkt_mty) && $stable(pkt_meta));

endmodule

`default_nettype wire

/* packet_playback.sv */
/* Packet playback top level on one clock. The packet always starts at
   memory address zero and the output carries no error flag. */
`timescale 1ns/10ps
`default_nettype none
`include "pb_defs.svh"

module packet_playback (
    input  logic                          clk,
    input  logic                          srst,
    input  logic                          reg_wr,
    input  logic                          reg_rd,
    input  logic [`PB_REG_ADDR_WID-1:0]   reg_addr,
    input  logic [31:0]                   reg_wdata,
    output logic [31:0]                   reg_rdata,
    output logic                          reg_rdata_vld,
    output logic                          pkt_valid,
    input  logic                          pkt_ready,
    output logic [`PB_DATA_WID-1:0]       pkt_data,
    output logic                          pkt_eop,
    output logic [`PB_MTY_WID-1:0]        pkt_mty,
    output logic [`PB_META_WID-1:0]       pkt_meta,
    output logic                          en
);
    import pb_pkg::*;

    logic                          enable;
    logic                          cmd_evt;
    pb_cmd_e                       cmd_code;
    logic [`PB_SIZE_WID-1:0]       packet_bytes;
    logic [`PB_SIZE_WID-1:0]       burst_size;
    logic [`PB_META_WID-1:0]       meta;
    pb_status_e                    status_code;
    logic                          done;
    logic                          error;
    logic                          timeout;
    logic                          desc_valid;
    logic [`PB_SIZE_WID-1:0]       desc_size;
    logic [`PB_META_WID-1:0]       desc_meta;
    logic                          desc_ready;
    logic                          mem_wr_en;
    logic [`PB_WIN_ADDR_WID-1:0]   mem_wr_addr;
    logic [31:0]                   mem_wr_data;
    logic                          rd_en;
    logic [`PB_MEM_ADDR_WID-1:0]   rd_addr;
    logic [`PB_DATA_WID-1:0]       rd_data;

    // Enable exported to the data plane
    always_ff @(posedge clk) begin
        if (srst) begin
            en <= 1'b0;
        end else begin
            en <= enable;
        end
    end

    pb_regs u_regs (
        .clk, .srst, .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_rdata_vld,
        .enable, .cmd_evt, .cmd_code, .packet_bytes, .burst_size, .meta,
        .status_code, .done, .error, .timeout,
        .mem_wr_en, .mem_wr_addr, .mem_wr_data
    );

    pb_ctrl u_ctrl (
        .clk, .srst, .enable, .cmd_evt, .cmd_code, .packet_bytes, .burst_size, .meta,
        .status_code, .done, .error, .timeout,
        .desc_valid, .desc_size, .desc_meta, .desc_ready
    );

    pb_packet_mem u_mem (
        .clk,
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_en, .rd_addr, .rd_data
    );

    pb_packet_read u_read (
        .clk, .srst, .desc_valid, .desc_size, .desc_meta, .desc_ready,
        .rd_en, .rd_addr, .rd_data,
        .pkt_valid, .pkt_ready, .pkt_data, .pkt_eop, .pkt_mty, .pkt_meta
    );

endmodule

`default_nettype wire

/* tb_packet_playback.sv */
/* Testbench for packet_playback. Payload bytes and pkt_ready throttling come
   from a 17-bit LFSR; the payload covers packets of up to 64 bytes. */
`timescale 1ns/10ps
`default_nettype none
`include "pb_defs.svh"

module tb_packet_playback;

    localparam int PAY_BYTES = 64;
    // Descriptor timeout test is the longest, about 1100 cycles
    localparam int RUN_LIMIT = 20000;

    logic                          clk;
    logic                          srst;
    logic                          reg_wr;
    logic                          reg_rd;
    logic [`PB_REG_ADDR_WID-1:0]   reg_addr;
    logic [31:0]                   reg_wdata;
    logic [31:0]                   reg_rdata;
    logic                          reg_rdata_vld;
    logic                          pkt_valid;
    logic                          pkt_ready;
    logic [`PB_DATA_WID-1:0]       pkt_data;
    logic                          pkt_eop;
    logic [`PB_MTY_WID-1:0]        pkt_mty;
    logic [`PB_META_WID-1:0]       pkt_meta;
    logic                          en;

    // Reference model of the packet stream
    logic [7:0]    pay [PAY_BYTES];
    int            cur_size;
    int            wd_idx;
    int            pkts_seen;
    int            words_seen;
    logic [63:0]   exp_data;
    logic [63:0]   exp_mask;
    logic          exp_eop;
    logic [2:0]    exp_mty;
    logic [31:0]   exp_meta;

    logic [16:0]   lfsr;
    int            ready_mode;  // 0 low, 1 high, 2 random
    int            cycles;

    packet_playback dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Failure reporting and random numbers
    // ------------------------------------------------------------------------
    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        $display("TESTS FAILED");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic logic random_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    // ------------------------------------------------------------------------
    // Model: byte 0 of the packet in the top byte of word 0
    // ------------------------------------------------------------------------
    function automatic logic [63:0] payload_word(input int idx);
        logic [63:0] w;
        w = '0;
        for (int k = 0; k < 8; k++) begin
            w = {w[55:0], pay[idx * 8 + k]};
        end
        return w;
    endfunction

    task automatic load_word(input int idx);
        int mty;
        mty      = (8 - cur_size % 8) % 8;
        wd_idx   = idx;
        exp_data = payload_word(idx);
        exp_eop  = (idx == (cur_size - 1) / 8);
        exp_mty  = exp_eop ? 3'(mty) : 3'd0;
        exp_mask = ~64'd0 << (8 * exp_mty);
    endtask

    task automatic expect_packet(input int size, input logic [31:0] meta);
        cur_size = size;
        exp_meta = meta;
        load_word(0);
    endtask

    always @(posedge clk) begin
        if (!srst && pkt_valid && pkt_ready) begin
            words_seen++;
            if (exp_eop) begin
                pkts_seen++;
                load_word(0);
            end else begin
                load_word(wd_idx + 1);
            end
        end
    end

    a_data : assert property (@(posedge clk) disable iff (srst)
        (pkt_valid && pkt_ready) |-> ((pkt_data & exp_mask) == (exp_data & exp_mask)))
        else report_mismatch("pkt_data", $sampled(pkt_data), $sampled(exp_data));
    a_eop : assert property (@(posedge clk) disable iff (srst)
        (pkt_valid && pkt_ready) |-> (pkt_eop == exp_eop))
        else report_mismatch("pkt_eop", $sampled(pkt_eop), $sampled(exp_eop));
    a_mty : assert property (@(posedge clk) disable iff (srst)
        (pkt_valid && pkt_ready) |-> (pkt_mty == exp_mty))
        else report_mismatch("pkt_mty", $sampled(pkt_mty), $sampled(exp_mty));
    a_meta : assert property (@(posedge clk) disable iff (srst)
        (pkt_valid && pkt_ready) |-> (pkt_meta == exp_meta))
        else report_mismatch("pkt_meta", $sampled(pkt_meta), $sampled(exp_meta));
    a_stall : assert property (@(posedge clk) disable iff (srst)
        (pkt_valid && !pkt_ready) |=> (pkt_valid && $stable(pkt_data) &&
            $stable(pkt_eop) && $stable(pkt_mty) && $stable(pkt_meta)))
        else abort_run("packet output changed while stalled");

    // ------------------------------------------------------------------------
    // Output throttling and run limit
    // ------------------------------------------------------------------------
    // Mode is taken at the edge, before the sequence can change it
    always @(posedge clk) begin : drive_ready
        int mode;
        mode = ready_mode;
        #1;
        if (mode == 2) begin
            pkt_ready = random_bit();
        end else begin
            pkt_ready = (mode == 1);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= RUN_LIMIT) begin
            abort_run("run did not finish within the cycle limit");
        end
    end

    // ------------------------------------------------------------------------
    // Register bus tasks, all entered 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input int addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = `PB_REG_ADDR_WID'(addr);
        reg_wdata = data;
        wait_cycles(1);
        reg_wr    = 1'b0;
    endtask

    task automatic read_reg(input int addr, output logic [31:0] data);
        reg_rd   = 1'b1;
        reg_addr = `PB_REG_ADDR_WID'(addr);
        wait_cycles(1);
        reg_rd   = 1'b0;
        assert (reg_rdata_vld) else abort_run("no read data one cycle after reg_rd");
        data = reg_rdata;
    endtask

    task automatic check_reg(input string name, input int addr, input logic [31:0] exp);
        logic [31:0] got;
        read_reg(addr, got);
        check_equal(name, got, exp);
    endtask

    task automatic fill_payload();
        logic [31:0] w;
        for (int i = 0; i < PAY_BYTES; i++) begin
            pay[i] = 8'h00;
            for (int k = 0; k < 8; k++) pay[i] = {pay[i][6:0], random_bit()};
        end
        for (int j = 0; j < PAY_BYTES / 4; j++) begin
            w = {pay[4 * j], pay[4 * j + 1], pay[4 * j + 2], pay[4 * j + 3]};
            write_reg(`PB_REG_DATA_BASE + j, w);
        end
    endtask

    task automatic start_command(input logic [15:0] burst, input logic [15:0] size,
                                 input logic [1:0] code);
        write_reg(`PB_REG_CONFIG, {burst, size});
        write_reg(`PB_REG_COMMAND, {30'd0, code});
    endtask

    // Poll until the flag shows, then expect it alone and cleared on the next read
    task automatic finish_command(input logic [31:0] flag);
        logic [31:0] st;
        st = '0;
        while ((st & flag) == 0) begin
            read_reg(`PB_REG_STATUS, st);
        end
        check_equal("STATUS", st, flag | 32'h1);
        check_reg("STATUS", `PB_REG_STATUS, 32'h1);
    endtask

    task automatic drain_output();
        int idle;
        idle = 0;
        while (idle < 8) begin
            wait_cycles(1);
            idle = pkt_valid ? 0 : idle + 1;
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int base_pkts;
        int base_words;
        srst       = 1'b1;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        pkt_ready  = 1'b1;
        ready_mode = 1;
        lfsr       = 17'd97795;
        cycles     = 0;
        pkts_seen  = 0;
        words_seen = 0;
        repeat (10) @(posedge clk);
        #1;
        srst = 1'b0;

        // Reset values, enable, INFO
        check_equal("en", en, 0);
        check_equal("pkt_valid", pkt_valid, 0);
        check_reg("STATUS", `PB_REG_STATUS, 32'h0);
        write_reg(`PB_REG_CONTROL, 32'h1);
        wait_cycles(2);
        check_equal("en", en, 1);
        check_reg("STATUS", `PB_REG_STATUS, 32'h1);
        // Metadata width 32, memory 2048 bytes
        check_reg("INFO", `PB_REG_INFO, 32'h0020_0800);
        fill_payload();

        // One packet of 29 bytes
        write_reg(`PB_REG_META, 32'ha5a5_0001);
        expect_packet(29, 32'ha5a5_0001);
        base_pkts  = pkts_seen;
        base_words = words_seen;
        start_command(16'd0, 16'd29, 2'd1);
        finish_command(32'h10);
        drain_output();
        check_equal("packets", pkts_seen - base_pkts, 1);
        check_equal("words", words_seen - base_words, 4);

        // Burst of three
        base_pkts = pkts_seen;
        start_command(16'd3, 16'd29, 2'd2);
        finish_command(32'h10);
        drain_output();
        check_equal("packets", pkts_seen - base_pkts, 3);

        // Continuous until STOP
        write_reg(`PB_REG_META, 32'h0bad_cafe);
        expect_packet(40, 32'h0bad_cafe);
        base_pkts = pkts_seen;
        start_command(16'd0, 16'd40, 2'd3);
        wait_cycles(30);
        write_reg(`PB_REG_COMMAND, 32'h0);
        finish_command(32'h10);
        drain_output();
        assert (pkts_seen - base_pkts >= 1) else abort_run("no packet sent before STOP");
        check_equal("wd_idx", wd_idx, 0);

        // Size zero is rejected
        base_pkts = pkts_seen;
        start_command(16'd0, 16'd0, 2'd1);
        finish_command(32'h20);
        drain_output();
        check_equal("packets", pkts_seen - base_pkts, 0);

        // Output held off, second descriptor of the burst times out
        ready_mode = 0;
        expect_packet(29, 32'h0bad_cafe);
        base_pkts = pkts_seen;
        start_command(16'd3, 16'd29, 2'd2);
        finish_command(32'h40);
        ready_mode = 1;
        drain_output();
        check_equal("packets", pkts_seen - base_pkts, 1);

        // Random back-pressure
        ready_mode = 2;
        write_reg(`PB_REG_META, 32'h1234_5678);
        expect_packet(50, 32'h1234_5678);
        base_pkts = pkts_seen;
        start_command(16'd4, 16'd50, 2'd2);
        finish_command(32'h10);
        drain_output();
        check_equal("packets", pkts_seen - base_pkts, 4);
        check_equal("wd_idx", wd_idx, 0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
pb_pkg.sv
pb_regs.sv
pb_ctrl.sv
pb_packet_mem.sv
pb_packet_read.sv
packet_playback.sv
tb_packet_playback.sv

/* Bender.yml */
package:
  name: packet_playback

sources:
  - include_dirs:
      - .
    files:
      - pb_pkg.sv
      - pb_regs.sv
      - pb_ctrl.sv
      - pb_packet_mem.sv
      - pb_packet_read.sv
      - packet_playback.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_packet_playback.sv
